//--- src/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////

  // Bus widths
  localparam int ADDR_W     = 16;
  localparam int DATA_W     = 32;
  // One strobe per byte lane
  localparam int STRB_W     = DATA_W / 8;

  // Write buffer, power of two so pointers wrap by themselves
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // Slave memory in words
  localparam int RAM_WORDS  = 256;
  localparam int RAM_AW     = $clog2(RAM_WORDS);

  //////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // Only sizes up to the bus width
  typedef enum logic [2:0] {
    HSIZE_B8  = 3'b000,
    HSIZE_B16 = 3'b001,
    HSIZE_B32 = 3'b010
  } hsize_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_e;

  // Burst master sequencing
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_ADDR = 2'b01,
    ST_LAST = 2'b10
  } m_state_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Host command, len only counts for INCR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    hsize_e            size;
    hburst_e           burst;
    logic              write;
    logic [4:0]        len;
  } burst_cmd_t;

  // Master to slave request, address phase plus write data
  typedef struct packed {
    logic [ADDR_W-1:0] haddr;
    logic              hwrite;
    hsize_e            hsize;
    hburst_e           hburst;
    htrans_e           htrans;
    logic [DATA_W-1:0] hwdata;
  } ahb_req_t;

endpackage

`default_nettype wire

//--- src/ahb_wdata_fifo.sv
`default_nettype none

module ahb_wdata_fifo (
  input  logic                       HCLK,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic [ahb_pkg::DATA_W-1:0] din,
  input  logic                       pop,
  output logic [ahb_pkg::DATA_W-1:0] head,
  output logic                       empty,
  output logic                       full
);

  logic [ahb_pkg::DATA_W-1:0]  mem [ahb_pkg::FIFO_DEPTH];
  logic [ahb_pkg::FIFO_AW-1:0] wptr;
  logic [ahb_pkg::FIFO_AW-1:0] rptr;
  logic [ahb_pkg::FIFO_AW:0]   count;
  logic                        do_push;
  logic                        do_pop;

  // Push into a full buffer only goes through alongside a pop
  assign do_push = push && (!full || pop);
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  // Depth is a power of two, so the top count bit means full
  assign full  = count[ahb_pkg::FIFO_AW];

  // Oldest entry, seen without a pop
  assign head = mem[rptr];

  // Storage
  always_ff @(posedge HCLK)
  begin
    if (do_push)
      mem[wptr] <= din;
  end

  // Pointers and occupancy
  always_ff @(posedge HCLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end
    else
    begin
      if (do_push)
        wptr <= wptr + 1'b1;
      if (do_pop)
        rptr <= rptr + 1'b1;
      // Count moves only when one side acts alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/ahb_burst_master.sv
`default_nettype none

module ahb_burst_master (
  input  logic                       HCLK,
  input  logic                       rst_n,
  input  ahb_pkg::burst_cmd_t        cmd,
  input  logic                       cmd_start,
  output logic                       busy,
  input  logic                       fifo_empty,
  input  logic [ahb_pkg::DATA_W-1:0] fifo_head,
  output logic                       fifo_pop,
  output ahb_pkg::ahb_req_t          req,
  input  logic [ahb_pkg::DATA_W-1:0] hrdata,
  input  logic                       hready,
  output logic [ahb_pkg::DATA_W-1:0] rdata,
  output logic                       rdata_valid
);

  // Beats in a burst, INCR takes the host count
  function automatic logic [4:0] burst_beats(ahb_pkg::hburst_e b, logic [4:0] len);
    case (b)
      ahb_pkg::HBURST_SINGLE: return 5'd1;
      ahb_pkg::HBURST_INCR:   return (len == 5'd0) ? 5'd1 : len;
      ahb_pkg::HBURST_WRAP4,
      ahb_pkg::HBURST_INCR4:  return 5'd4;
      ahb_pkg::HBURST_WRAP8,
      ahb_pkg::HBURST_INCR8:  return 5'd8;
      default:                return 5'd16;
    endcase
  endfunction

  // Bytes per beat
  function automatic logic [2:0] size_bytes(ahb_pkg::hsize_e s);
    case (s)
      ahb_pkg::HSIZE_B8:  return 3'd1;
      ahb_pkg::HSIZE_B16: return 3'd2;
      default:            return 3'd4;
    endcase
  endfunction

  // Valid low bytes of a beat
  function automatic logic [ahb_pkg::DATA_W-1:0] size_mask(ahb_pkg::hsize_e s);
    case (s)
      ahb_pkg::HSIZE_B8:  return 32'h0000_00ff;
      ahb_pkg::HSIZE_B16: return 32'h0000_ffff;
      default:            return 32'hffff_ffff;
    endcase
  endfunction

  ahb_pkg::m_state_e          state;
  ahb_pkg::htrans_e           htrans;
  ahb_pkg::hsize_e            hsize_q;
  ahb_pkg::hburst_e           hburst_q;
  ahb_pkg::hsize_e            dp_size;
  logic [ahb_pkg::ADDR_W-1:0] haddr_q;
  logic [ahb_pkg::ADDR_W-1:0] step;
  logic [ahb_pkg::ADDR_W-1:0] wrap_mask;
  logic [ahb_pkg::ADDR_W-1:0] next_addr;
  logic [ahb_pkg::DATA_W-1:0] hwdata_q;
  logic [4:0]                 beats_left;
  logic [4:0]                 beats_fixed;
  logic [1:0]                 dp_off;
  logic                       hwrite_q;
  logic                       pend;
  logic                       first;
  logic                       hold_q;
  logic                       stall_q;
  logic                       stall;
  logic                       xfer;
  logic                       dp_valid;
  logic                       dp_write;

  //////////////////////////////////////////////////
  // Address stepping
  //////////////////////////////////////////////////

  always_comb
  begin
    step        = {{(ahb_pkg::ADDR_W-3){1'b0}}, size_bytes(hsize_q)};
    // INCR counts as one beat here, only WRAP uses the mask
    beats_fixed = burst_beats(hburst_q, 5'd1);
    wrap_mask   = step * {{(ahb_pkg::ADDR_W-5){1'b0}}, beats_fixed} - 1'b1;
    if (hburst_q inside {ahb_pkg::HBURST_WRAP4, ahb_pkg::HBURST_WRAP8,
                         ahb_pkg::HBURST_WRAP16})
      next_addr = (haddr_q & ~wrap_mask) | ((haddr_q + step) & wrap_mask);
    else
      next_addr = haddr_q + step;
  end

  //////////////////////////////////////////////////
  // Transfer type
  //////////////////////////////////////////////////

  // Write beat waits on an empty buffer
  // During a wait state the previous choice is kept so HTRANS holds
  assign stall = hold_q ? stall_q : (hwrite_q && fifo_empty);

  always_comb
  begin
    if (!pend)
      htrans = ahb_pkg::HTRANS_IDLE;
    else if (stall)
      htrans = first ? ahb_pkg::HTRANS_IDLE : ahb_pkg::HTRANS_BUSY;
    else
      htrans = first ? ahb_pkg::HTRANS_NONSEQ : ahb_pkg::HTRANS_SEQ;
  end

  // A real beat sits in the address phase
  assign xfer     = pend && !stall;
  // Head leaves the buffer as its address phase completes
  assign fifo_pop = hready && xfer && hwrite_q;
  assign busy     = (state != ahb_pkg::ST_IDLE);

  always_comb
  begin
    req.haddr  = haddr_q;
    req.hwrite = hwrite_q;
    req.hsize  = hsize_q;
    req.hburst = hburst_q;
    req.htrans = htrans;
    req.hwdata = hwdata_q;
  end

  //////////////////////////////////////////////////
  // Burst FSM
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= ahb_pkg::ST_IDLE;
      haddr_q    <= '0;
      hwrite_q   <= 1'b0;
      hsize_q    <= ahb_pkg::HSIZE_B8;
      hburst_q   <= ahb_pkg::HBURST_SINGLE;
      beats_left <= '0;
      pend       <= 1'b0;
      first      <= 1'b0;
      hold_q     <= 1'b0;
      stall_q    <= 1'b0;
    end
    else
    begin
      hold_q  <= !hready;
      stall_q <= stall;
      case (state)
        ahb_pkg::ST_IDLE:
        begin
          // Latch the command, NONSEQ follows one edge later
          if (cmd_start)
          begin
            haddr_q    <= cmd.addr;
            hwrite_q   <= cmd.write;
            hsize_q    <= cmd.size;
            hburst_q   <= cmd.burst;
            beats_left <= burst_beats(cmd.burst, cmd.len);
            first      <= 1'b1;
            state      <= ahb_pkg::ST_ADDR;
          end
        end
        ahb_pkg::ST_ADDR:
        begin
          if (hready)
          begin
            if (!pend)
              pend <= 1'b1;
            else if (xfer)
            begin
              first <= 1'b0;
              // last address out, only its data phase remains
              if (beats_left == 5'd1)
              begin
                pend  <= 1'b0;
                state <= ahb_pkg::ST_LAST;
              end
              else
              begin
                beats_left <= beats_left - 1'b1;
                haddr_q    <= next_addr;
              end
            end
          end
        end
        ahb_pkg::ST_LAST:
        begin
          if (hready && dp_valid)
            state <= ahb_pkg::ST_IDLE;
        end
        default:
          state <= ahb_pkg::ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Data phase
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dp_valid    <= 1'b0;
      rdata_valid <= 1'b0;
    end
    else
    begin
      if (hready)
        dp_valid <= xfer;
      // One cycle after the read data phase completes
      rdata_valid <= hready && dp_valid && !dp_write;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (hready && xfer)
    begin
      dp_write <= hwrite_q;
      dp_size  <= hsize_q;
      dp_off   <= haddr_q[1:0];
      // Beat moves up onto its byte lanes
      if (hwrite_q)
        hwdata_q <= (fifo_head & size_mask(hsize_q)) << {haddr_q[1:0], 3'b000};
    end
    // Read beat comes back down to bit 0
    if (hready && dp_valid && !dp_write)
      rdata <= (hrdata >> {dp_off, 3'b000}) & size_mask(dp_size);
  end

endmodule

`default_nettype wire

//--- src/ahb_ram_slave.sv
`default_nettype none

module ahb_ram_slave (
  input  logic                       HCLK,
  input  logic                       rst_n,
  input  ahb_pkg::ahb_req_t          req,
  output logic [ahb_pkg::DATA_W-1:0] hrdata,
  output logic                       hready
);

  logic [ahb_pkg::DATA_W-1:0] mem [ahb_pkg::RAM_WORDS];
  logic [ahb_pkg::ADDR_W-1:0] dp_addr;
  logic [ahb_pkg::RAM_AW-1:0] dp_word;
  logic [ahb_pkg::STRB_W-1:0] lanes;
  logic [ahb_pkg::STRB_W-1:0] byte_en;
  ahb_pkg::hsize_e            dp_size;
  logic [7:0]                 lfsr;
  logic [1:0]                 wait_cnt;
  logic                       dp_valid;
  logic                       dp_write;
  logic                       take;
  logic                       done;

  // New address phase is sampled only with hready high
  assign take = hready && (req.htrans inside {ahb_pkg::HTRANS_NONSEQ, ahb_pkg::HTRANS_SEQ});

  // Data phase ends once the wait count runs out
  assign done    = dp_valid && (wait_cnt == 2'd0);
  assign hready  = !dp_valid || (wait_cnt == 2'd0);
  assign dp_word = dp_addr[ahb_pkg::RAM_AW+1:2];

  //////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////

  always_comb
  begin
    case (dp_size)
      ahb_pkg::HSIZE_B8:  lanes = 4'b0001;
      ahb_pkg::HSIZE_B16: lanes = 4'b0011;
      default:            lanes = 4'b1111;
    endcase
    byte_en = lanes << dp_addr[1:0];
  end

  // Whole word, the master picks its bytes
  assign hrdata = done ? mem[dp_word] : '0;

  //////////////////////////////////////////////////
  // Wait states
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lfsr     <= 8'ha5;
      dp_valid <= 1'b0;
      wait_cnt <= 2'd0;
    end
    else
    begin
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (take)
      begin
        dp_valid <= 1'b1;
        wait_cnt <= lfsr[1:0];
      end
      else if (hready)
        dp_valid <= 1'b0;
      else
        wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // Address phase copy for the data phase
  always_ff @(posedge HCLK)
  begin
    if (take)
    begin
      dp_addr  <= req.haddr;
      dp_write <= req.hwrite;
      dp_size  <= req.hsize;
    end
  end

  // Write on the completing edge, selected lanes only
  always_ff @(posedge HCLK)
  begin
    if (done && dp_write)
    begin
      for (int i = 0; i < ahb_pkg::STRB_W; i++)
      begin
        if (byte_en[i])
          mem[dp_word][i*8 +: 8] <= req.hwdata[i*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/ahb_burst_top.sv
`default_nettype none

module ahb_burst_top (
  input  logic                       HCLK,
  input  logic                       rst_n,
  input  ahb_pkg::burst_cmd_t        cmd,
  input  logic                       cmd_start,
  output logic                       busy,
  input  logic                       wdata_push,
  input  logic [ahb_pkg::DATA_W-1:0] wdata,
  output logic                       wdata_full,
  output logic [ahb_pkg::DATA_W-1:0] rdata,
  output logic                       rdata_valid
);

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////

  // Buffer to master
  logic                       fifo_empty;
  logic                       fifo_pop;
  logic [ahb_pkg::DATA_W-1:0] fifo_head;

  // AHB between master and RAM
  ahb_pkg::ahb_req_t          req;
  logic [ahb_pkg::DATA_W-1:0] hrdata;
  logic                       hready;

  // Host write beats
  ahb_wdata_fifo ahb_wdata_fifo_i (
    .HCLK  (HCLK),
    .rst_n (rst_n),
    .push  (wdata_push),
    .din   (wdata),
    .pop   (fifo_pop),
    .head  (fifo_head),
    .empty (fifo_empty),
    .full  (wdata_full)
  );

  ahb_burst_master ahb_burst_master_i (
    .HCLK        (HCLK),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_start   (cmd_start),
    .busy        (busy),
    .fifo_empty  (fifo_empty),
    .fifo_head   (fifo_head),
    .fifo_pop    (fifo_pop),
    .req         (req),
    .hrdata      (hrdata),
    .hready      (hready),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  // Single slave, no decoder
  ahb_ram_slave ahb_ram_slave_i (
    .HCLK   (HCLK),
    .rst_n  (rst_n),
    .req    (req),
    .hrdata (hrdata),
    .hready (hready)
  );

endmodule

`default_nettype wire

//--- test/tb_ahb_model.svh
`ifndef TB_AHB_MODEL_SVH
`define TB_AHB_MODEL_SVH

//////////////////////////////////////////////////
// Reference memory and address rules
//////////////////////////////////////////////////

// Byte mirror of the slave RAM where higher address bits alias
localparam int MIRROR_BYTES = ahb_pkg::RAM_WORDS * (ahb_pkg::DATA_W / 8);

logic [7:0] mirror [MIRROR_BYTES];

// Beats per burst with INCR following the host count
function automatic int beats_of(ahb_pkg::hburst_e burst, logic [4:0] len);
  case (burst)
    ahb_pkg::HBURST_SINGLE: return 1;
    ahb_pkg::HBURST_INCR:   return (len == 5'd0) ? 1 : int'(len);
    ahb_pkg::HBURST_WRAP4,
    ahb_pkg::HBURST_INCR4:  return 4;
    ahb_pkg::HBURST_WRAP8,
    ahb_pkg::HBURST_INCR8:  return 8;
    default:                return 16;
  endcase
endfunction

function automatic int bytes_of(ahb_pkg::hsize_e size);
  case (size)
    ahb_pkg::HSIZE_B8:  return 1;
    ahb_pkg::HSIZE_B16: return 2;
    default:            return 4;
  endcase
endfunction

function automatic bit is_wrap(ahb_pkg::hburst_e burst);
  return burst inside {ahb_pkg::HBURST_WRAP4, ahb_pkg::HBURST_WRAP8,
                       ahb_pkg::HBURST_WRAP16};
endfunction

// Next beat address where a WRAP burst stays inside its block
function automatic logic [15:0] next_addr_of(logic [15:0] addr, ahb_pkg::hsize_e size,
                                            ahb_pkg::hburst_e burst);
  int step;
  int block;
  int base;
  step = bytes_of(size);
  if (is_wrap(burst))
  begin
    // Offset inside the block rolls over to the block start
    block = step * beats_of(burst, 5'd1);
    base  = int'(addr) - (int'(addr) % block);
    return 16'(base + (int'(addr) - base + step) % block);
  end
  else
    return 16'(int'(addr) + step);
endfunction

// Low bytes of the beat land at the address and up
function automatic void mirror_write(logic [15:0] addr, ahb_pkg::hsize_e size,
                                     logic [31:0] data);
  for (int i = 0; i < bytes_of(size); i++)
    mirror[(int'(addr) + i) % MIRROR_BYTES] = data[8*i +: 8];
endfunction

// Read beat as the host sees it with upper bytes zero
function automatic logic [31:0] mirror_read(logic [15:0] addr, ahb_pkg::hsize_e size);
  logic [31:0] result;
  result = '0;
  for (int i = 0; i < bytes_of(size); i++)
    result[8*i +: 8] = mirror[(int'(addr) + i) % MIRROR_BYTES];
  return result;
endfunction

`endif

//--- test/tb_ahb_burst.sv
`default_nettype none

module tb_ahb_burst;

  //////////////////////////////////////////////////
  // Run limits
  //////////////////////////////////////////////////

  // Worst case per burst is 16 beats of up to 5 cycles
  localparam int MAX_BURSTS     = 64;
  localparam int MAX_BEATS      = 16;
  localparam int BEAT_CYCLES    = 5;
  localparam int MARGIN         = 2000;
  localparam int TIMEOUT_CYCLES = MAX_BURSTS * MAX_BEATS * BEAT_CYCLES + MARGIN;

  logic                       HCLK;
  logic                       rst_n;
  ahb_pkg::burst_cmd_t        cmd;
  logic                       cmd_start;
  logic                       busy;
  logic                       wdata_push;
  logic [ahb_pkg::DATA_W-1:0] wdata;
  logic                       wdata_full;
  logic [ahb_pkg::DATA_W-1:0] rdata;
  logic                       rdata_valid;

  // Bookkeeping
  int          cycles;
  int          errors;
  int          checks;
  int          tests;
  int          tests_bad;
  int          test_err_base;
  int unsigned seed;

  ahb_pkg::hsize_e  size_list [3];
  ahb_pkg::hburst_e incr_list [3];
  ahb_pkg::hburst_e wrap_list [3];

  `include "tb_ahb_model.svh"

  ahb_burst_top ahb_burst_top_i (
    .HCLK        (HCLK),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_start   (cmd_start),
    .busy        (busy),
    .wdata_push  (wdata_push),
    .wdata       (wdata),
    .wdata_full  (wdata_full),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

  // 4 unit clock
  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK;
  end

  // Watchdog
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge HCLK);
      cycles++;
    end
    $display("Timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic start_test();
    test_err_base = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err_base)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      tests_bad++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
    end
  endtask

  //////////////////////////////////////////////////
  // Random picks
  //////////////////////////////////////////////////

  function automatic ahb_pkg::hsize_e pick_size();
    return size_list[$urandom_range(2, 0)];
  endfunction

  // Any RAM address aligned to the beat size
  function automatic logic [15:0] pick_addr(ahb_pkg::hsize_e size);
    logic [15:0] a;
    a = 16'($urandom_range(MIRROR_BYTES - 1, 0));
    return a & ~16'(bytes_of(size) - 1);
  endfunction

  //////////////////////////////////////////////////
  // Host side bursts
  //////////////////////////////////////////////////

  // Called on a falling edge with busy low and returns one edge after acceptance
  task automatic issue_cmd(input logic [15:0] addr, input ahb_pkg::hsize_e size,
                           input ahb_pkg::hburst_e burst, input logic write,
                           input logic [4:0] len);
    cmd.addr  = addr;
    cmd.size  = size;
    cmd.burst = burst;
    cmd.write = write;
    cmd.len   = len;
    cmd_start = 1'b1;
    @(negedge HCLK);
    cmd_start = 1'b0;
    check_value("busy after cmd_start", 32'(busy), 32'd1);
  endtask

  task automatic run_write(input logic [15:0] addr, input ahb_pkg::hsize_e size,
                           input ahb_pkg::hburst_e burst, input logic [4:0] len,
                           input int prefill, input int drops, input int gap);
    logic [31:0] beats [$];
    logic [15:0] a;
    int          n;
    int          pushed;
    int          idle_left;
    n = beats_of(burst, len);
    a = addr;
    // Mirror takes every beat the FIFO accepts
    for (int i = 0; i < n; i++)
    begin
      beats.push_back($urandom);
      mirror_write(a, size, beats[i]);
      a = next_addr_of(a, size, burst);
    end
    // Beats buffered while the bus is idle
    pushed = 0;
    while (pushed < prefill && pushed < n)
    begin
      wdata_push = 1'b1;
      wdata      = beats[pushed];
      pushed++;
      @(negedge HCLK);
    end
    // Junk against a full FIFO would show up as a wrong beat
    for (int i = 0; i < drops; i++)
    begin
      check_value("wdata_full", 32'(wdata_full), 32'd1);
      wdata_push = 1'b1;
      wdata      = ~beats[pushed % n];
      @(negedge HCLK);
    end
    wdata_push = 1'b0;
    issue_cmd(addr, size, burst, 1'b1, len);
    idle_left = 0;
    // Rest of the beats paced by gap and by wdata_full
    while (pushed < n || busy)
    begin
      wdata_push = 1'b0;
      if (idle_left > 0)
        idle_left--;
      else if (pushed < n && !wdata_full)
      begin
        wdata_push = 1'b1;
        wdata      = beats[pushed];
        pushed++;
        idle_left  = (gap > 0) ? int'($urandom_range(gap, 1)) : 0;
      end
      @(negedge HCLK);
    end
    wdata_push = 1'b0;
  endtask

  task automatic run_read(input logic [15:0] addr, input ahb_pkg::hsize_e size,
                          input ahb_pkg::hburst_e burst, input logic [4:0] len);
    logic [31:0] exp_q  [$];
    logic [31:0] got_q  [$];
    logic [15:0] addr_q [$];
    logic [15:0] a;
    int          n;
    n = beats_of(burst, len);
    a = addr;
    for (int i = 0; i < n; i++)
    begin
      addr_q.push_back(a);
      exp_q.push_back(mirror_read(a, size));
      a = next_addr_of(a, size, burst);
    end
    issue_cmd(addr, size, burst, 1'b0, len);
    while (busy)
    begin
      if (rdata_valid)
        got_q.push_back(rdata);
      @(negedge HCLK);
    end
    // Last beat can come with busy already low
    // a few idle cycles catch stray pulses
    repeat (3)
    begin
      if (rdata_valid)
        got_q.push_back(rdata);
      @(negedge HCLK);
    end
    check_value("rdata_valid count", got_q.size(), n);
    for (int i = 0; i < n && i < got_q.size(); i++)
      check_value($sformatf("rdata beat %0d at %h", i, addr_q[i]), got_q[i], exp_q[i]);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    ahb_pkg::hsize_e  size;
    ahb_pkg::hburst_e burst;
    logic [15:0]      addr;
    logic [4:0]       len;
    int               block;

    seed      = 32'h8543;
    void'($urandom(seed));
    errors    = 0;
    checks    = 0;
    tests     = 0;
    tests_bad = 0;
    size_list = '{ahb_pkg::HSIZE_B8, ahb_pkg::HSIZE_B16, ahb_pkg::HSIZE_B32};
    incr_list = '{ahb_pkg::HBURST_INCR4, ahb_pkg::HBURST_INCR8, ahb_pkg::HBURST_INCR16};
    wrap_list = '{ahb_pkg::HBURST_WRAP4, ahb_pkg::HBURST_WRAP8, ahb_pkg::HBURST_WRAP16};

    // Every input known from time zero
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_start  = 1'b0;
    wdata_push = 1'b0;
    wdata      = '0;
    repeat (3) @(negedge HCLK);
    rst_n = 1'b1;
    @(negedge HCLK);

    start_test();
    check_value("busy", 32'(busy), 32'd0);
    check_value("rdata_valid", 32'(rdata_valid), 32'd0);
    check_value("wdata_full", 32'(wdata_full), 32'd0);
    end_test("reset");

    // Whole RAM gets known contents first
    start_test();
    for (int k = 0; k < 16; k++)
      run_write(16'(k * 64), ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR16, 5'd0, 8, 0, 0);
    end_test("ram_fill");

    // Single beats at every size
    for (int s = 0; s < 3; s++)
    begin
      start_test();
      repeat (4)
      begin
        addr = pick_addr(size_list[s]);
        run_write(addr, size_list[s], ahb_pkg::HBURST_SINGLE, 5'd0, 1, 0, 0);
        run_read(addr, size_list[s], ahb_pkg::HBURST_SINGLE, 5'd0);
      end
      end_test($sformatf("single_%s", size_list[s].name()));
    end

    // Fixed incrementing bursts
    for (int b = 0; b < 3; b++)
    begin
      start_test();
      size = pick_size();
      addr = pick_addr(size);
      run_write(addr, size, incr_list[b], 5'd0, 8, 0, 0);
      run_read(addr, size, incr_list[b], 5'd0);
      end_test($sformatf("%s_%s", incr_list[b].name(), size.name()));
    end

    // Wrapping bursts start off the block boundary
    for (int b = 0; b < 3; b++)
    begin
      start_test();
      burst = wrap_list[b];
      size  = pick_size();
      addr  = pick_addr(size);
      block = bytes_of(size) * beats_of(burst, 5'd1);
      if ((int'(addr) & (block - 1)) == 0)
        addr = 16'(int'(addr) + bytes_of(size));
      run_write(addr, size, burst, 5'd0, 8, 0, 0);
      run_read(addr, size, burst, 5'd0);
      end_test($sformatf("%s_%s", burst.name(), size.name()));
    end

    // Undefined length with nothing buffered at the start
    repeat (4)
    begin
      start_test();
      size = pick_size();
      addr = pick_addr(size);
      len  = 5'($urandom_range(16, 1));
      run_write(addr, size, ahb_pkg::HBURST_INCR, len, 0, 0, 0);
      run_read(addr, size, ahb_pkg::HBURST_INCR, len);
      end_test($sformatf("incr_len_%0d", len));
    end

    // One beat buffered and the rest trickling in so the master inserts BUSY
    start_test();
    addr = pick_addr(ahb_pkg::HSIZE_B32);
    run_write(addr, ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR8, 5'd0, 1, 0, 5);
    run_read(addr, ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR8, 5'd0);
    end_test("slow_push");

    // Pushes into a full FIFO are lost
    start_test();
    addr = pick_addr(ahb_pkg::HSIZE_B32);
    run_write(addr, ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR16, 5'd0, 8, 3, 0);
    run_read(addr, ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR16, 5'd0);
    end_test("full_drop");

    // Full read back also covers bytes outside every burst
    start_test();
    for (int k = 0; k < 16; k++)
      run_read(16'(k * 64), ahb_pkg::HSIZE_B32, ahb_pkg::HBURST_INCR16, 5'd0);
    end_test("ram_sweep");

    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests, tests_bad, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+test
src/ahb_pkg.sv
src/ahb_wdata_fifo.sv
src/ahb_burst_master.sv
src/ahb_ram_slave.sv
src/ahb_burst_top.sv
test/tb_ahb_burst.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_ahb_burst
FILELIST = tb.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) test/tb_ahb_model.svh
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
